// ==== sources.f ====
source/paillier_pkg.sv
source/key_regs.sv
source/mod_mult.sv
source/mod_exp.sv
source/paillier_ctrl.sv
source/paillier_top.sv
verif/paillier_tb.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

if ! verilator --binary --timing --assert -Wno-fatal \
        --top-module paillier_tb -Mdir "$BUILD_DIR" -f sources.f; then
    echo "build failed"
    exit 1
fi

if ! "./$BUILD_DIR/Vpaillier_tb" > "$LOG" 2>&1; then
    cat "$LOG"
    echo "simulation exited with an error"
    exit 1
fi
cat "$LOG"

if grep -q "=== PASS ===" "$LOG"; then
    echo "result: pass"
    exit 0
else
    echo "result: fail"
    exit 1
fi

// ==== verif/paillier_tb.sv ====
`timescale 1ns/1ns

module paillier_tb;
    import paillier_pkg::*;

    typedef logic [63:0] wide_t;

    localparam int CLK_PERIOD        = 10;
    // 10 + 10 + 30 tasks plus the rejected-request tasks, rounded up
    localparam int TASK_COUNT        = 60;
    // 32 squares and 32 multiplies of about 35 cycles each
    localparam int WORST_TASK_CYCLES = 2300;
    localparam int IDLE_CYCLES       = 24000;
    localparam int RESULT_TIMEOUT    = 2 * WORST_TASK_CYCLES;
    localparam int WATCHDOG_NS       =
        (2 * TASK_COUNT * WORST_TASK_CYCLES + IDLE_CYCLES) * CLK_PERIOD;

    logic       clk = 1'b0;
    logic       rst_n;
    logic       key_load;
    key_t       key_n;
    logic       task_req;
    task_cmd_t  task_cmd;
    cipher_t    op_a;
    cipher_t    op_b;
    cipher_t    result;
    logic       result_valid;
    logic       busy;

    int         seed = 32'h46a9;
    int         error_count = 0;
    int         pass_count = 0;
    int         fail_count = 0;
    int         test_errors_start = 0;
    key_t       cur_n;
    cipher_t    last_expected;

    always #(CLK_PERIOD / 2) clk = ~clk;

    paillier_top dut0 (
            .clk            (clk            )
        ,   .rst_n          (rst_n          )
        ,   .key_load       (key_load       )
        ,   .key_n          (key_n          )
        ,   .task_req       (task_req       )
        ,   .task_cmd       (task_cmd       )
        ,   .op_a           (op_a           )
        ,   .op_b           (op_b           )
        ,   .result         (result         )
        ,   .result_valid   (result_valid   )
        ,   .busy           (busy           )
    );

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog: run did not finish within %0d ns", WATCHDOG_NS);
        $display("=== FAIL ===");
        $finish;
    end

    function automatic wide_t mulmod(input wide_t a, input wide_t b, input wide_t m);
        return (a * b) % m;
    endfunction

    // Right-to-left binary exponentiation
    function automatic wide_t powmod(input wide_t base, input exp_t e, input wide_t m);
        wide_t acc;
        wide_t sq;
        acc = 64'd1 % m;
        sq  = base % m;
        for (int i = 0; i < EXP_W; i++) begin
            if (e[i]) begin
                acc = mulmod(acc, sq, m);
            end
            sq = mulmod(sq, sq, m);
        end
        return acc;
    endfunction

    function automatic cipher_t sq_of(input key_t n);
        return cipher_t'(wide_t'(n) * wide_t'(n));
    endfunction

    function automatic cipher_t hom_add_ref(input cipher_t c1, input cipher_t c2, input key_t n);
        return cipher_t'(mulmod(wide_t'(c1), wide_t'(c2), wide_t'(sq_of(n))));
    endfunction

    function automatic cipher_t scalar_ref(input cipher_t c, input exp_t k, input key_t n);
        return cipher_t'(powmod(wide_t'(c), k, wide_t'(sq_of(n))));
    endfunction

    // Generator n+1 gives g^m = 1 + m*n mod n^2
    function automatic cipher_t enc_ref(input cipher_t m, input cipher_t r, input key_t n);
        wide_t nsq;
        wide_t gm;
        nsq = wide_t'(sq_of(n));
        gm  = (64'd1 + wide_t'(m) * wide_t'(n)) % nsq;
        return cipher_t'(mulmod(gm, powmod(wide_t'(r), exp_t'(n), nsq), nsq));
    endfunction

    function automatic cipher_t rand_below(input cipher_t bound);
        cipher_t v;
        v = $random(seed);
        return v % bound;
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic check_cipher(input string name, input cipher_t expected, input cipher_t actual);
        if (actual !== expected) begin
            $display("FAIL %s: expected 0x%08h, actual 0x%08h", name, expected, actual);
            error_count++;
        end
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("FAIL %s: expected %b, actual %b", name, expected, actual);
            error_count++;
        end
    endtask

    task automatic begin_test();
        test_errors_start = error_count;
    endtask

    task automatic end_test(input string name);
        if (error_count == test_errors_start) begin
            pass_count++;
            $display("%s: passed", name);
        end else begin
            fail_count++;
            $display("%s: failed with %0d errors", name, error_count - test_errors_start);
        end
    endtask

    task automatic load_key(input key_t k);
        key_n    = k;
        key_load = 1'b1;
        next_cycle();
        key_load = 1'b0;
        cur_n    = k;
    endtask

    task automatic issue_task(input task_cmd_t cmd, input cipher_t a, input cipher_t b);
        task_req = 1'b1;
        task_cmd = cmd;
        op_a     = a;
        op_b     = b;
        next_cycle();
        task_req = 1'b0;
    endtask

    // Busy must hold until the cycle of the result_valid pulse
    task automatic wait_result(input string name, output cipher_t res);
        int   cycles;
        logic got;
        logic busy_gap;
        cycles   = 0;
        got      = 1'b0;
        busy_gap = 1'b0;
        res      = '0;
        while (!got && (cycles < RESULT_TIMEOUT)) begin
            if (result_valid) begin
                got = 1'b1;
                res = result;
                check_bit({name, " busy at result_valid"}, 1'b0, busy);
            end else begin
                if (!busy) begin
                    busy_gap = 1'b1;
                end
                next_cycle();
                cycles++;
            end
        end
        if (!got) begin
            $display("%s: no result_valid within %0d cycles", name, RESULT_TIMEOUT);
            error_count++;
        end else begin
            check_bit({name, " busy dropped early"}, 1'b0, busy_gap);
        end
    endtask

    task automatic run_and_check(input string name, input task_cmd_t cmd, input cipher_t a,
                                 input cipher_t b, input cipher_t expected);
        cipher_t res;
        issue_task(cmd, a, b);
        wait_result(name, res);
        check_cipher(name, expected, res);
        last_expected = expected;
    endtask

    task automatic expect_idle(input string name, input int cycles);
        logic busy_seen;
        logic valid_seen;
        busy_seen  = 1'b0;
        valid_seen = 1'b0;
        repeat (cycles) begin
            if (busy) begin
                busy_seen = 1'b1;
            end
            if (result_valid) begin
                valid_seen = 1'b1;
            end
            next_cycle();
        end
        check_bit({name, " busy"}, 1'b0, busy_seen);
        check_bit({name, " result_valid"}, 1'b0, valid_seen);
    endtask

    task automatic test_reset();
        begin_test();
        check_bit("reset busy", 1'b0, busy);
        check_bit("reset result_valid", 1'b0, result_valid);
        // No key loaded yet
        issue_task(CMD_HOM_ADD, 32'd5, 32'd7);
        expect_idle("request without key", 20);
        end_test("reset");
    endtask

    task automatic test_hom_add();
        cipher_t nsq;
        cipher_t c1;
        cipher_t c2;
        begin_test();
        load_key(16'd3233);
        nsq = sq_of(cur_n);
        for (int i = 0; i < 10; i++) begin
            c1 = rand_below(nsq);
            c2 = rand_below(nsq);
            run_and_check($sformatf("hom_add[%0d]", i), CMD_HOM_ADD, c1, c2,
                          hom_add_ref(c1, c2, cur_n));
        end
        end_test("hom_add");
    endtask

    task automatic test_scalar_mul();
        cipher_t nsq;
        cipher_t c;
        exp_t    k;
        begin_test();
        nsq = sq_of(cur_n);
        for (int i = 0; i < 10; i++) begin
            c = rand_below(nsq);
            if (i < 2) begin
                k = exp_t'(i);
            end else begin
                k = $random(seed);
            end
            run_and_check($sformatf("scalar_mul[%0d]", i), CMD_SCALAR_MUL, c, cipher_t'(k),
                          scalar_ref(c, k, cur_n));
        end
        end_test("scalar_mul");
    endtask

    task automatic test_encrypt(input key_t k);
        cipher_t m;
        cipher_t r;
        begin_test();
        load_key(k);
        for (int i = 0; i < 10; i++) begin
            m = rand_below(cipher_t'(k));
            r = 32'd1 + rand_below(cipher_t'(k) - 32'd1);
            run_and_check($sformatf("encrypt n=%0d [%0d]", k, i), CMD_ENCRYPT, m, r,
                          enc_ref(m, r, k));
        end
        end_test($sformatf("encrypt n=%0d", k));
    endtask

    task automatic test_rejected();
        cipher_t nsq;
        cipher_t c1;
        cipher_t c2;
        cipher_t res;
        begin_test();
        load_key(16'd3233);
        nsq  = sq_of(cur_n);
        issue_task(CMD_DECRYPT, 32'd5, 32'd7);
        expect_idle("decrypt request", 20);
        check_cipher("decrypt result held", last_expected, result);

        c1 = rand_below(nsq);
        c2 = rand_below(nsq);
        task_req = 1'b1;
        task_cmd = CMD_HOM_ADD;
        op_a     = c1;
        op_b     = c2;
        next_cycle();
        // Second request and a new key arrive while the first task runs
        task_cmd = CMD_SCALAR_MUL;
        op_a     = c2;
        op_b     = 32'd3;
        key_n    = 16'd59989;
        key_load = 1'b1;
        next_cycle();
        task_req = 1'b0;
        key_load = 1'b0;
        wait_result("busy overlap", res);
        check_cipher("busy overlap", hom_add_ref(c1, c2, cur_n), res);
        // Step past the result_valid pulse of the first task
        next_cycle();
        expect_idle("busy overlap second result", 20);
        // Same product again shows the key stayed at 3233
        run_and_check("key kept", CMD_HOM_ADD, c1, c2, hom_add_ref(c1, c2, cur_n));
        end_test("rejected");
    endtask

    initial begin
        rst_n         = 1'b0;
        key_load      = 1'b0;
        key_n         = '0;
        task_req      = 1'b0;
        task_cmd      = CMD_ENCRYPT;
        op_a          = '0;
        op_b          = '0;
        cur_n         = '0;
        last_expected = '0;
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;
        next_cycle();

        test_reset();
        test_hom_add();
        test_scalar_mul();
        test_rejected();
        test_encrypt(16'd3233);
        test_encrypt(16'd59989);
        test_encrypt(16'd3);

        $display("tests: %0d passed, %0d failed, %0d check errors",
                 pass_count, fail_count, error_count);
        if ((fail_count == 0) && (error_count == 0)) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// ==== source/paillier_top.sv ====
`timescale 1ns/1ns

module paillier_top (
        input  logic                        clk
    ,   input  logic                        rst_n
    ,   input  logic                        key_load
    ,   input  paillier_pkg::key_t          key_n
    ,   input  logic                        task_req
    ,   input  paillier_pkg::task_cmd_t     task_cmd
    ,   input  paillier_pkg::cipher_t       op_a
    ,   input  paillier_pkg::cipher_t       op_b
    ,   output paillier_pkg::cipher_t       result
    ,   output logic                        result_valid
    ,   output logic                        busy
);
    import paillier_pkg::*;

    key_t       n;
    cipher_t    n_sq;
    logic       key_valid;

    logic       mult_start;
    cipher_t    mult_a;
    cipher_t    mult_b;
    cipher_t    mult_mod;
    cipher_t    mult_result;
    logic       mult_done;

    logic       exp_start;
    cipher_t    exp_base;
    exp_t       exp_exp;
    cipher_t    exp_mod;
    cipher_t    exp_result;
    logic       exp_done;

    key_regs key0 (
            .clk        (clk        )
        ,   .rst_n      (rst_n      )
        ,   .key_load   (key_load   )
        ,   .key_n      (key_n      )
        ,   .busy       (busy       )
        ,   .n          (n          )
        ,   .n_sq       (n_sq       )
        ,   .key_valid  (key_valid  )
    );

    paillier_ctrl ctrl0 (
            .clk            (clk            )
        ,   .rst_n          (rst_n          )
        ,   .task_req       (task_req       )
        ,   .task_cmd       (task_cmd       )
        ,   .op_a           (op_a           )
        ,   .op_b           (op_b           )
        ,   .n              (n              )
        ,   .n_sq           (n_sq           )
        ,   .key_valid      (key_valid      )
        ,   .mult_start     (mult_start     )
        ,   .mult_a         (mult_a         )
        ,   .mult_b         (mult_b         )
        ,   .mult_mod       (mult_mod       )
        ,   .exp_start      (exp_start      )
        ,   .exp_base       (exp_base       )
        ,   .exp_exp        (exp_exp        )
        ,   .exp_mod        (exp_mod        )
        ,   .mult_result    (mult_result    )
        ,   .mult_done      (mult_done      )
        ,   .exp_result     (exp_result     )
        ,   .exp_done       (exp_done       )
        ,   .result         (result         )
        ,   .result_valid   (result_valid   )
        ,   .busy           (busy           )
    );

    mod_mult mult0 (
            .clk        (clk        )
        ,   .rst_n      (rst_n      )
        ,   .start      (mult_start )
        ,   .a          (mult_a     )
        ,   .b          (mult_b     )
        ,   .modulus    (mult_mod   )
        ,   .result     (mult_result)
        ,   .done       (mult_done  )
    );

    mod_exp exp0 (
            .clk        (clk        )
        ,   .rst_n      (rst_n      )
        ,   .start      (exp_start  )
        ,   .base       (exp_base   )
        ,   .exponent   (exp_exp    )
        ,   .modulus    (exp_mod    )
        ,   .result     (exp_result )
        ,   .done       (exp_done   )
    );

endmodule

// ==== source/paillier_ctrl.sv ====
`timescale 1ns/1ns

module paillier_ctrl (
        input  logic                        clk
    ,   input  logic                        rst_n
    ,   input  logic                        task_req
    ,   input  paillier_pkg::task_cmd_t     task_cmd
    ,   input  paillier_pkg::cipher_t       op_a
    ,   input  paillier_pkg::cipher_t       op_b
    ,   input  paillier_pkg::key_t          n
    ,   input  paillier_pkg::cipher_t       n_sq
    ,   input  logic                        key_valid
    ,   output logic                        mult_start
    ,   output paillier_pkg::cipher_t       mult_a
    ,   output paillier_pkg::cipher_t       mult_b
    ,   output paillier_pkg::cipher_t       mult_mod
    ,   output logic                        exp_start
    ,   output paillier_pkg::cipher_t       exp_base
    ,   output paillier_pkg::exp_t          exp_exp
    ,   output paillier_pkg::cipher_t       exp_mod
    ,   input  paillier_pkg::cipher_t       mult_result
    ,   input  logic                        mult_done
    ,   input  paillier_pkg::cipher_t       exp_result
    ,   input  logic                        exp_done
    ,   output paillier_pkg::cipher_t       result
    ,   output logic                        result_valid
    ,   output logic                        busy
);
    import paillier_pkg::*;

    ctrl_state_t    state;
    logic           accept;
    cipher_t        op_a_r;
    cipher_t        op_b_r;
    key_t           n_r;
    cipher_t        n_sq_r;
    cipher_t        rn_r;
    cipher_t        gm_r;

    assign accept = (state == ST_IDLE) && task_req && key_valid &&
                    (task_cmd != CMD_DECRYPT);

    assign mult_mod = n_sq_r;
    assign exp_mod  = n_sq_r;

    always_comb begin
        mult_a = op_a_r;
        mult_b = op_b_r;
        case (state)
            ST_ENC_GM: begin
                mult_b = cipher_t'(n_r);
            end
            ST_ENC_MUL: begin
                mult_a = rn_r;
                mult_b = gm_r;
            end
            default: begin
            end
        endcase
    end

    // Encryption raises r to n, scalar multiply raises c to k
    always_comb begin
        if (state == ST_SCALAR_MUL) begin
            exp_base = op_a_r;
            exp_exp  = exp_t'(op_b_r);
        end else begin
            exp_base = op_b_r;
            exp_exp  = exp_t'(n_r);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state        <= ST_IDLE;
            busy         <= 1'b0;
            result_valid <= 1'b0;
            mult_start   <= 1'b0;
            exp_start    <= 1'b0;
        end else begin
            result_valid <= 1'b0;
            mult_start   <= 1'b0;
            exp_start    <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (accept) begin
                        busy <= 1'b1;
                        case (task_cmd)
                            CMD_ENCRYPT: begin
                                state     <= ST_ENC_EXP;
                                exp_start <= 1'b1;
                            end
                            CMD_HOM_ADD: begin
                                state      <= ST_HOM_ADD;
                                mult_start <= 1'b1;
                            end
                            CMD_SCALAR_MUL: begin
                                state     <= ST_SCALAR_MUL;
                                exp_start <= 1'b1;
                            end
                            default: begin
                                state <= ST_IDLE;
                            end
                        endcase
                    end
                end
                ST_ENC_EXP: begin
                    if (exp_done) begin
                        state      <= ST_ENC_GM;
                        mult_start <= 1'b1;
                    end
                end
                ST_ENC_GM: begin
                    if (mult_done) begin
                        state      <= ST_ENC_MUL;
                        mult_start <= 1'b1;
                    end
                end
                ST_ENC_MUL, ST_HOM_ADD: begin
                    if (mult_done) begin
                        state <= ST_DONE;
                    end
                end
                ST_SCALAR_MUL: begin
                    if (exp_done) begin
                        state <= ST_DONE;
                    end
                end
                ST_DONE: begin
                    result_valid <= 1'b1;
                    busy         <= 1'b0;
                    state        <= ST_IDLE;
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            op_a_r <= op_a;
            op_b_r <= op_b;
            n_r    <= n;
            n_sq_r <= n_sq;
        end
        if ((state == ST_ENC_EXP) && exp_done) begin
            rn_r <= exp_result;
        end
        // m*n mod n^2 plus one stays below n^2 since m < n
        if ((state == ST_ENC_GM) && mult_done) begin
            gm_r <= mult_result + cipher_t'(1);
        end
        if (((state == ST_ENC_MUL) || (state == ST_HOM_ADD)) && mult_done) begin
            result <= mult_result;
        end
        if ((state == ST_SCALAR_MUL) && exp_done) begin
            result <= exp_result;
        end
    end

    a_valid_ends_busy: assert property (
        @(posedge clk) disable iff (!rst_n)
        result_valid |-> !busy ##1 !result_valid
    ) else $error("paillier_ctrl: result_valid overlaps busy");

endmodule

// ==== source/mod_exp.sv ====
`timescale 1ns/1ns

module mod_exp (
        input  logic                    clk
    ,   input  logic                    rst_n
    ,   input  logic                    start
    ,   input  paillier_pkg::cipher_t   base
    ,   input  paillier_pkg::exp_t      exponent
    ,   input  paillier_pkg::cipher_t   modulus
    ,   output paillier_pkg::cipher_t   result
    ,   output logic                    done
);
    import paillier_pkg::*;

    exp_state_t     state;
    bit_cnt_t       cnt;
    logic           accept;
    logic           last_bit;
    logic           advance;
    cipher_t        base_r;
    exp_t           exp_r;
    cipher_t        mod_r;
    cipher_t        acc;
    logic           mm_start;
    cipher_t        mm_b;
    cipher_t        mm_result;
    logic           mm_done;

    assign accept   = start && (state == EX_IDLE);
    assign last_bit = (cnt == '0);
    // Move to the next exponent bit once its square and optional multiply are in
    assign advance  = mm_done && (((state == EX_SQUARE) && !exp_r[EXP_W-1]) ||
                                  (state == EX_MULT));
    assign mm_b     = (state == EX_MULT) ? base_r : acc;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= EX_IDLE;
            cnt      <= '0;
            mm_start <= 1'b0;
            done     <= 1'b0;
        end else begin
            mm_start <= 1'b0;
            done     <= 1'b0;
            case (state)
                EX_IDLE: begin
                    if (accept) begin
                        state    <= EX_SQUARE;
                        cnt      <= bit_cnt_t'(EXP_W - 1);
                        mm_start <= 1'b1;
                    end
                end
                EX_SQUARE: begin
                    if (mm_done) begin
                        if (exp_r[EXP_W-1]) begin
                            state    <= EX_MULT;
                            mm_start <= 1'b1;
                        end else if (last_bit) begin
                            state <= EX_DONE;
                        end else begin
                            cnt      <= cnt - 1'b1;
                            mm_start <= 1'b1;
                        end
                    end
                end
                EX_MULT: begin
                    if (mm_done) begin
                        if (last_bit) begin
                            state <= EX_DONE;
                        end else begin
                            state    <= EX_SQUARE;
                            cnt      <= cnt - 1'b1;
                            mm_start <= 1'b1;
                        end
                    end
                end
                EX_DONE: begin
                    done  <= 1'b1;
                    state <= EX_IDLE;
                end
                default: begin
                    state <= EX_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            base_r <= base;
            exp_r  <= exponent;
            mod_r  <= modulus;
            acc    <= cipher_t'(1);
        end else if (mm_done) begin
            acc <= mm_result;
        end
        if (advance) begin
            exp_r <= exp_r << 1;
        end
        if (state == EX_DONE) begin
            result <= acc;
        end
    end

    mod_mult mm0 (
            .clk        (clk        )
        ,   .rst_n      (rst_n      )
        ,   .start      (mm_start   )
        ,   .a          (acc        )
        ,   .b          (mm_b       )
        ,   .modulus    (mod_r      )
        ,   .result     (mm_result  )
        ,   .done       (mm_done    )
    );

    a_done_pulse: assert property (
        @(posedge clk) disable iff (!rst_n)
        done |=> !done
    ) else $error("mod_exp: done longer than one cycle");

endmodule

// ==== source/mod_mult.sv ====
`timescale 1ns/1ns

module mod_mult (
        input  logic                    clk
    ,   input  logic                    rst_n
    ,   input  logic                    start
    ,   input  paillier_pkg::cipher_t   a
    ,   input  paillier_pkg::cipher_t   b
    ,   input  paillier_pkg::cipher_t   modulus
    ,   output paillier_pkg::cipher_t   result
    ,   output logic                    done
);
    import paillier_pkg::*;

    logic                   run;
    logic                   fin;
    logic                   idle;
    logic                   accept;
    bit_cnt_t               cnt;
    cipher_t                a_r;
    cipher_t                b_r;
    cipher_t                mod_r;
    cipher_t                acc;
    logic [CIPHER_W+1:0]    sum;
    logic [CIPHER_W+1:0]    red1;
    logic [CIPHER_W+1:0]    red2;
    logic [CIPHER_W+1:0]    mod_ext;

    assign idle   = !run && !fin;
    assign accept = start && idle;

    // 2*acc + a stays below three times the modulus
    assign mod_ext = {2'b00, mod_r};
    assign sum     = {1'b0, acc, 1'b0} + (b_r[CIPHER_W-1] ? {2'b00, a_r} : '0);
    assign red1    = (sum >= mod_ext) ? (sum - mod_ext) : sum;
    assign red2    = (red1 >= mod_ext) ? (red1 - mod_ext) : red1;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            run  <= 1'b0;
            fin  <= 1'b0;
            done <= 1'b0;
            cnt  <= '0;
        end else begin
            fin  <= 1'b0;
            done <= fin;
            if (accept) begin
                run <= 1'b1;
                cnt <= bit_cnt_t'(CIPHER_W - 1);
            end else if (run) begin
                cnt <= cnt - 1'b1;
                if (cnt == '0) begin
                    run <= 1'b0;
                    fin <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            a_r   <= a;
            b_r   <= b;
            mod_r <= modulus;
            acc   <= '0;
        end else if (run) begin
            acc <= red2[CIPHER_W-1:0];
            b_r <= b_r << 1;
        end
        if (fin) begin
            result <= acc;
        end
    end

    a_no_start_busy: assert property (
        @(posedge clk) disable iff (!rst_n)
        start |-> idle
    ) else $error("mod_mult: start while busy");

    a_result_reduced: assert property (
        @(posedge clk) disable iff (!rst_n)
        done |-> (result < mod_r)
    ) else $error("mod_mult: result not below modulus");

endmodule

// ==== source/key_regs.sv ====
`timescale 1ns/1ns

module key_regs (
        input  logic                    clk
    ,   input  logic                    rst_n
    ,   input  logic                    key_load
    ,   input  paillier_pkg::key_t      key_n
    ,   input  logic                    busy
    ,   output paillier_pkg::key_t      n
    ,   output paillier_pkg::cipher_t   n_sq
    ,   output logic                    key_valid
);
    import paillier_pkg::*;

    logic load_en;

    // A running task keeps the key it started with
    assign load_en = key_load && !busy;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            key_valid <= 1'b0;
        end else if (load_en) begin
            key_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (load_en) begin
            n    <= key_n;
            // 16 x 16 product always fits the ciphertext width
            n_sq <= cipher_t'(key_n) * cipher_t'(key_n);
        end
    end

    // Odd modulus of at least 3 keeps n+1 a valid generator
    a_key_legal: assert property (
        @(posedge clk) disable iff (!rst_n)
        load_en |-> (key_n[0] && (key_n >= key_t'(3)))
    ) else $error("key_regs: illegal modulus loaded");

endmodule

// ==== source/paillier_pkg.sv ====
package paillier_pkg;

    localparam int KEY_W    = 16;
    localparam int CIPHER_W = 32;
    localparam int EXP_W    = 32;

    // Bit counter wide enough for the longer of the operand and exponent scans
    localparam int CNT_W    = $clog2((CIPHER_W > EXP_W) ? CIPHER_W : EXP_W);

    typedef logic [KEY_W-1:0]    key_t;
    typedef logic [CIPHER_W-1:0] cipher_t;
    typedef logic [EXP_W-1:0]    exp_t;
    typedef logic [CNT_W-1:0]    bit_cnt_t;

    typedef enum logic [1:0] {
        CMD_ENCRYPT    = 2'b00,
        CMD_DECRYPT    = 2'b01,  // reserved, never accepted
        CMD_HOM_ADD    = 2'b10,
        CMD_SCALAR_MUL = 2'b11
    } task_cmd_t;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_ENC_EXP,
        ST_ENC_GM,
        ST_ENC_MUL,
        ST_HOM_ADD,
        ST_SCALAR_MUL,
        ST_DONE
    } ctrl_state_t;

    typedef enum logic [1:0] {
        EX_IDLE,
        EX_SQUARE,
        EX_MULT,
        EX_DONE
    } exp_state_t;

endpackage
